/* Makefile */
# Verilator build, run, lint and clean for the cpu front end

VERILATOR ?= verilator
TOP ?= tb_cpu_frontend
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
# checker errors are counted so the testbench can report them
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cpu_frontend.sv */
`timescale 1ns/1ps

module cpu_frontend (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rdy_in,
  input  rv_pkg::byte_t     mem_din,
  output rv_pkg::byte_t     mem_dout,
  output rv_pkg::addr_t     mem_a,
  output logic              mem_wr,
  input  rv_pkg::wb_req_t   wb_req,
  output rv_pkg::wb_rsp_t   wb_rsp,
  input  rv_pkg::redirect_t redirect,
  output logic              inst_valid,
  output rv_pkg::inst_t     inst,
  input  logic              inst_ready
);

  rv_pkg::fetch_req_t fetch_req;
  rv_pkg::fetch_rsp_t fetch_rsp;
  rv_pkg::addr_t lookup_pc;
  logic hit;
  rv_pkg::word_t hit_inst;

  mem_ctrler mem_ctrler_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .mem_din   (mem_din),
    .mem_dout  (mem_dout),
    .mem_a     (mem_a),
    .mem_wr    (mem_wr)
  );

  icache icache_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .lookup_pc (lookup_pc),
    .hit       (hit),
    .hit_inst  (hit_inst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp)
  );

  inst_fetcher inst_fetcher_i (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_in     (rdy_in),
    .lookup_pc  (lookup_pc),
    .hit        (hit),
    .hit_inst   (hit_inst),
    .redirect   (redirect),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready)
  );

endmodule

/* cpu_frontend_chk.sv */
`timescale 1ns/1ps

module cpu_frontend_chk (
  input logic              clk_in,
  input logic              rst_in,
  input logic              rdy_in,
  input logic              mem_wr,
  input rv_pkg::wb_req_t   wb_req,
  input rv_pkg::wb_rsp_t   wb_rsp,
  input logic              inst_valid,
  input rv_pkg::inst_t     inst,
  input logic              inst_ready
);

  int fail_count = 0;

  // stalled hand-off keeps its payload
  assert property (@(posedge clk_in) disable iff (rst_in)
    inst_valid && !inst_ready |=> $stable(inst))
  else begin
    fail_count++;
    $error("inst changed while the issuer stalled");
  end

  assert property (@(posedge clk_in) disable iff (rst_in)
    wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
  else begin
    fail_count++;
    $error("wishbone ack without cyc and stb");
  end

  assert property (@(posedge clk_in) disable iff (rst_in)
    wb_rsp.ack |=> !wb_rsp.ack)
  else begin
    fail_count++;
    $error("wishbone ack longer than one cycle");
  end

  // ram writes only while running
  assert property (@(posedge clk_in) disable iff (rst_in)
    !rdy_in |-> !mem_wr)
  else begin
    fail_count++;
    $error("mem_wr high during a pause");
  end

  assert property (@(posedge clk_in)
    rst_in |=> !inst_valid && !wb_rsp.ack && !mem_wr)
  else begin
    fail_count++;
    $error("outputs not idle after reset");
  end

endmodule

/* icache.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module icache (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               rdy_in,
  input  rv_pkg::addr_t      lookup_pc,
  output logic               hit,
  output rv_pkg::word_t      hit_inst,
  output rv_pkg::fetch_req_t fetch_req,
  input  rv_pkg::fetch_rsp_t fetch_rsp
);

  rv_pkg::line_t data_mem [`RV_ICACHE_LINES];
  logic [`RV_TAG_W-1:0] tag_mem [`RV_ICACHE_LINES];
  logic [`RV_ICACHE_LINES-1:0] valid_bits;

  logic [`RV_INDEX_W-1:0] pc_index;
  logic [`RV_TAG_W-1:0] pc_tag;
  logic [`RV_OFFSET_W-3:0] pc_word;
  rv_pkg::line_t cur_line;

  logic req_valid;
  rv_pkg::addr_t req_addr;
  logic [`RV_INDEX_W-1:0] fill_index;
  logic [`RV_TAG_W-1:0] fill_tag;
  logic fill_now;

  assign pc_word = lookup_pc[`RV_OFFSET_W-1:2];
  assign pc_index = lookup_pc[`RV_OFFSET_W +: `RV_INDEX_W];
  assign pc_tag = lookup_pc[`RV_ADDR_W-1 -: `RV_TAG_W];

  // lookup against the fetcher pc without a pipeline
  assign cur_line = data_mem[pc_index];
  assign hit = valid_bits[pc_index] && (tag_mem[pc_index] == pc_tag);
  assign hit_inst = cur_line[`RV_WORD_W*pc_word +: `RV_WORD_W];

  assign fill_index = req_addr[`RV_OFFSET_W +: `RV_INDEX_W];
  assign fill_tag = req_addr[`RV_ADDR_W-1 -: `RV_TAG_W];
  assign fill_now = req_valid && fetch_rsp.ready;

  assign fetch_req.valid = req_valid;
  assign fetch_req.addr = req_addr;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_bits <= '0;
      req_valid <= 1'b0;
    end else if (rdy_in) begin
      if (req_valid) begin
        if (fetch_rsp.ready) begin
          req_valid <= 1'b0;
          valid_bits[fill_index] <= 1'b1;
        end
      end else if (!hit) begin
        req_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      // address frozen while the refill is outstanding
      if (!req_valid) begin
        req_addr <= lookup_pc & ~rv_pkg::addr_t'(`RV_LINE_BYTES - 1);
      end
      if (fill_now) begin
        data_mem[fill_index] <= fetch_rsp.line;
        tag_mem[fill_index] <= fill_tag;
      end
    end
  end

endmodule

/* inst_fetcher.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module inst_fetcher (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rdy_in,
  output rv_pkg::addr_t     lookup_pc,
  input  logic              hit,
  input  rv_pkg::word_t     hit_inst,
  input  rv_pkg::redirect_t redirect,
  output logic              inst_valid,
  output rv_pkg::inst_t     inst,
  input  logic              inst_ready
);

  rv_pkg::addr_t pc;
  logic out_valid;
  logic taken;
  logic load;

  assign lookup_pc = pc;

  // no hand-off while paused
  assign inst_valid = out_valid && rdy_in;
  assign taken = inst_valid && inst_ready;

  // refill the output register when empty or emptied this cycle
  assign load = hit && (!out_valid || taken);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc <= `RV_RESET_PC;
      out_valid <= 1'b0;
    end else if (rdy_in) begin
      if (redirect.valid) begin
        pc <= redirect.pc;
        out_valid <= 1'b0;
      end else if (load) begin
        pc <= pc + rv_pkg::addr_t'(4);
        out_valid <= 1'b1;
      end else if (taken) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && !redirect.valid && load) begin
      inst.pc <= pc;
      inst.inst <= hit_inst;
    end
  end

endmodule

/* mem_ctrler.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module mem_ctrler (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               rdy_in,
  input  rv_pkg::fetch_req_t fetch_req,
  output rv_pkg::fetch_rsp_t fetch_rsp,
  input  rv_pkg::wb_req_t    wb_req,
  output rv_pkg::wb_rsp_t    wb_rsp,
  input  rv_pkg::byte_t      mem_din,
  output rv_pkg::byte_t      mem_dout,
  output rv_pkg::addr_t      mem_a,
  output logic               mem_wr
);

  rv_pkg::mem_state_e state;
  rv_pkg::addr_t base;
  rv_pkg::word_t wdata;
  rv_pkg::line_t line_buf;
  logic is_write;
  logic [`RV_OFFSET_W:0] cnt;
  logic [`RV_OFFSET_W-1:0] recv_cnt;
  logic recv_vld;
  logic rdy_q;
  logic fill_rdy;
  logic data_ack;

  logic data_go;
  logic fill_go;
  logic cur_fill;
  logic cur_we;
  rv_pkg::addr_t cur_base;
  rv_pkg::word_t cur_dat;
  logic [`RV_OFFSET_W:0] last;
  logic [`RV_OFFSET_W:0] idx;
  logic active;
  logic issuing;
  logic got;
  logic done;

  // a request still high in its own ack cycle is not new
  assign data_go = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
  assign fill_go = fetch_req.valid && !fetch_rsp.ready;

  always_comb begin
    cur_base = base;
    cur_dat = wdata;
    cur_we = is_write;
    cur_fill = (state == rv_pkg::FILL);
    idx = cnt;
    if (state == rv_pkg::IDLE) begin
      // data side wins and its first byte goes out right away
      idx = '0;
      cur_fill = !data_go;
      if (data_go) begin
        cur_base = wb_req.adr;
        cur_dat = wb_req.dat;
        cur_we = wb_req.we;
      end else begin
        cur_base = fetch_req.addr;
        cur_we = 1'b0;
      end
    end else if (rdy_in && recv_vld && !rdy_q) begin
      // byte due during the pause was dropped so fetch it again
      idx = {1'b0, recv_cnt};
    end
  end

  assign last = cur_fill ? (`RV_OFFSET_W + 1)'(`RV_LINE_BYTES - 1)
                         : (`RV_OFFSET_W + 1)'(`RV_WORD_BYTES - 1);
  assign active = (state != rv_pkg::IDLE) || data_go || fill_go;
  assign issuing = active && (idx <= last);
  assign got = (state != rv_pkg::IDLE) && recv_vld && rdy_q;
  assign done = cur_we ? ((state != rv_pkg::IDLE) && (idx == last))
                       : (got && ({1'b0, recv_cnt} == last));

  assign mem_a = cur_base + rv_pkg::addr_t'(idx);
  assign mem_dout = cur_dat[8*idx[1:0] +: 8];
  assign mem_wr = rdy_in && cur_we && issuing;

  assign fetch_rsp.ready = fill_rdy;
  assign fetch_rsp.line = line_buf;
  assign wb_rsp.ack = data_ack;
  assign wb_rsp.dat = line_buf[`RV_WORD_W-1:0];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= rv_pkg::IDLE;
      cnt <= '0;
      recv_vld <= 1'b0;
      rdy_q <= 1'b0;
      fill_rdy <= 1'b0;
      data_ack <= 1'b0;
    end else begin
      rdy_q <= rdy_in;
      // wishbone ack is one cycle even across a pause
      data_ack <= rdy_in && done && (state == rv_pkg::DATA);
      if (rdy_in) begin
        fill_rdy <= done && (state == rv_pkg::FILL);
        recv_vld <= issuing && !cur_we;
        cnt <= idx + 1'b1;
        if (state == rv_pkg::IDLE) begin
          if (data_go) begin
            state <= rv_pkg::DATA;
          end else if (fill_go) begin
            state <= rv_pkg::FILL;
          end
        end else if (done) begin
          state <= rv_pkg::IDLE;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      recv_cnt <= idx[`RV_OFFSET_W-1:0];
      if (state == rv_pkg::IDLE) begin
        base <= cur_base;
        wdata <= cur_dat;
        is_write <= cur_we;
      end
      if (got) begin
        line_buf[8*recv_cnt +: 8] <= mem_din;
      end
    end
  end

endmodule

/* rv_pkg.sv */
`include "rv_settings.svh"

package rv_pkg;

  typedef logic [`RV_ADDR_W-1:0] addr_t;
  typedef logic [`RV_WORD_W-1:0] word_t;
  typedef logic [7:0] byte_t;
  // byte 0 sits in the low bits
  typedef logic [`RV_LINE_W-1:0] line_t;

  // icache line refill
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic  ready;
    line_t line;
  } fetch_rsp_t;

  // wishbone classic with whole words only
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    word_t dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  typedef struct packed {
    addr_t pc;
    word_t inst;
  } inst_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
  } redirect_t;

  typedef enum logic [1:0] {
    IDLE,
    FILL,
    DATA
  } mem_state_e;

endpackage

/* rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// bus widths
`define RV_ADDR_W 32
`define RV_WORD_W 32
`define RV_WORD_BYTES (`RV_WORD_W / 8)

// instruction cache geometry
`define RV_LINE_BYTES 16
`define RV_ICACHE_LINES 16
`define RV_LINE_W (`RV_LINE_BYTES * 8)

// address split into tag, index and offset
`define RV_OFFSET_W ($clog2(`RV_LINE_BYTES))
`define RV_INDEX_W ($clog2(`RV_ICACHE_LINES))
`define RV_TAG_W (`RV_ADDR_W - `RV_OFFSET_W - `RV_INDEX_W)

// first fetch address
`define RV_RESET_PC 32'h0000_0000

`endif

/* tb_cpu_frontend.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_cpu_frontend;

  localparam int RAM_BYTES = 131072;
  localparam int XFER_TARGET = 400;
  localparam int ACK_TARGET = 40;
  localparam int RUN_LIMIT = 40000;
  localparam int IDLE_LIMIT = 600;
  localparam int WB_LIMIT = 200;

  typedef enum logic [2:0] {
    WB_IDLE,
    WB_WRITE,
    WB_WRITE_ACKED,
    WB_READ,
    WB_READ_ACKED
  } wb_step_e;

  logic clk_in;
  logic rst_in;
  logic rdy_in;
  rv_pkg::byte_t mem_din = '0;
  rv_pkg::byte_t mem_dout;
  rv_pkg::addr_t mem_a;
  logic mem_wr;
  rv_pkg::wb_req_t wb_req;
  rv_pkg::wb_rsp_t wb_rsp;
  rv_pkg::redirect_t redirect;
  logic inst_valid;
  rv_pkg::inst_t inst;
  logic inst_ready;

  rv_pkg::byte_t ram [RAM_BYTES];
  // expected data image that follows every acked write
  rv_pkg::byte_t shadow [RAM_BYTES];
  logic [31:0] lfsr_state;
  int xfer_count;
  int ack_count;
  rv_pkg::addr_t exp_pc;
  // wishbone access currently in flight
  logic acc_we;
  rv_pkg::addr_t acc_adr;
  rv_pkg::word_t acc_dat;

  cpu_frontend cpu_frontend_i (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_in     (rdy_in),
    .mem_din    (mem_din),
    .mem_dout   (mem_dout),
    .mem_a      (mem_a),
    .mem_wr     (mem_wr),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .redirect   (redirect),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready)
  );

  bind cpu_frontend cpu_frontend_chk chk_i (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_in     (rdy_in),
    .mem_wr     (mem_wr),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  // little-endian word at pc in the ram model
  function automatic rv_pkg::word_t ref_word(input rv_pkg::addr_t pc);
    logic [16:0] a;
    a = pc[16:0];
    return {ram[a + 17'd3], ram[a + 17'd2], ram[a + 17'd1], ram[a]};
  endfunction

  function automatic rv_pkg::word_t shadow_word(input rv_pkg::addr_t adr);
    logic [16:0] a;
    a = adr[16:0];
    return {shadow[a + 17'd3], shadow[a + 17'd2], shadow[a + 17'd1], shadow[a]};
  endfunction

  task automatic check_ack();
    rv_pkg::word_t got;
    logic [16:0] a;
    a = acc_adr[16:0];
    if (acc_we) begin
      got = ref_word(acc_adr);
      assert (got == acc_dat) else fail_run($sformatf(
        "FAILED at %0t: ram word at %h got %h expected %h", $time, acc_adr, got, acc_dat));
      for (int i = 0; i < 4; i++) begin
        shadow[a + 17'(i)] = acc_dat[8*i +: 8];
      end
    end else begin
      got = shadow_word(acc_adr);
      assert (wb_rsp.dat == got) else fail_run($sformatf(
        "FAILED at %0t: wb_rsp.dat got %h expected %h", $time, wb_rsp.dat, got));
    end
    ack_count++;
  endtask

  initial begin
    clk_in = 1'b0;
    forever begin
      #4 clk_in = ~clk_in;
    end
  end

  // byte ram with read data one cycle after the address
  always @(posedge clk_in) begin
    mem_din <= ram[mem_a[16:0]];
    if (mem_wr) begin
      ram[mem_a[16:0]] = mem_dout;
    end
  end

  initial begin : compare_proc
    int idle;
    rv_pkg::word_t exp_word;
    idle = 0;
    forever begin
      @(negedge clk_in);
      #2;
      assert (cpu_frontend_i.chk_i.fail_count == 0)
        else fail_run("a concurrent assertion on cpu_frontend fired");
      if (!rst_in) begin
        idle++;
        if (inst_valid && inst_ready) begin
          idle = 0;
          exp_word = ref_word(exp_pc);
          assert (inst.pc == exp_pc) else fail_run($sformatf(
            "FAILED at %0t: inst.pc got %h expected %h", $time, inst.pc, exp_pc));
          assert (inst.inst == exp_word) else fail_run($sformatf(
            "FAILED at %0t: inst.inst got %h expected %h", $time, inst.inst, exp_word));
          exp_pc = exp_pc + 32'd4;
          xfer_count++;
        end
        // a redirect lands after any transfer in the same cycle
        if (redirect.valid && rdy_in) begin
          exp_pc = redirect.pc;
        end
        if (wb_rsp.ack) begin
          check_ack();
        end
        assert (idle <= IDLE_LIMIT)
          else fail_run("no instruction was handed to the issuer for too many cycles");
      end
    end
  end

  initial begin : stimulus_proc
    int cycles;
    int wb_wait;
    wb_step_e wb_step;
    rst_in = 1'b1;
    rdy_in = 1'b1;
    inst_ready = 1'b0;
    wb_req = '0;
    redirect = '0;
    xfer_count = 0;
    ack_count = 0;
    exp_pc = `RV_RESET_PC;
    acc_we = 1'b0;
    acc_adr = '0;
    acc_dat = '0;
    lfsr_state = 32'hbe098000;
    for (int i = 0; i < RAM_BYTES; i++) begin
      ram[17'(i)] = rv_pkg::byte_t'(rand_bits(8));
      shadow[17'(i)] = ram[17'(i)];
    end
    repeat (5) @(negedge clk_in);
    rst_in = 1'b0;
    cycles = 0;
    wb_wait = 0;
    wb_step = WB_IDLE;
    while (xfer_count < XFER_TARGET || ack_count < ACK_TARGET) begin
      @(negedge clk_in);
      cycles++;
      assert (cycles <= RUN_LIMIT)
        else fail_run("the run did not reach its transfer and ack counts in time");
      // pressure grows with progress
      inst_ready = (xfer_count < 32) ? 1'b1 : (rand_bits(2) != 32'd0);
      rdy_in = (xfer_count < 220) ? 1'b1 : (rand_bits(3) != 32'd0);
      redirect = '0;
      if (xfer_count >= 120 && rdy_in && rand_bits(5) == 32'd0) begin
        redirect.valid = 1'b1;
        redirect.pc = rv_pkg::addr_t'(rand_bits(13) << 2);
      end
      case (wb_step)
        WB_IDLE: begin
          if (xfer_count >= 120 && rand_bits(2) == 32'd0) begin
            acc_we = 1'b1;
            acc_adr = 32'h0001_0000 | rv_pkg::addr_t'(rand_bits(14) << 2);
            acc_dat = rand_bits(32);
            wb_req = {1'b1, 1'b1, 1'b1, acc_adr, acc_dat};
            wb_wait = 0;
            wb_step = WB_WRITE;
          end
        end
        WB_WRITE: begin
          if (wb_rsp.ack) begin
            wb_step = WB_WRITE_ACKED;
          end
        end
        WB_WRITE_ACKED: begin
          // read back the word just written
          acc_we = 1'b0;
          wb_req = {1'b1, 1'b1, 1'b0, acc_adr, 32'd0};
          wb_wait = 0;
          wb_step = WB_READ;
        end
        WB_READ: begin
          if (wb_rsp.ack) begin
            wb_step = WB_READ_ACKED;
          end
        end
        default: begin
          wb_req = '0;
          wb_step = WB_IDLE;
        end
      endcase
      if (wb_step == WB_WRITE || wb_step == WB_READ) begin
        wb_wait++;
        assert (wb_wait <= WB_LIMIT)
          else fail_run("a wishbone access was not acknowledged in time");
      end
    end
    if (cpu_frontend_i.chk_i.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      fail_run("a concurrent assertion on cpu_frontend fired");
    end
  end

endmodule

/* verilog.f */
+incdir+.
rv_pkg.sv
mem_ctrler.sv
icache.sv
inst_fetcher.sv
cpu_frontend.sv
cpu_frontend_chk.sv
tb_cpu_frontend.sv
